// ==== vlog.f ====
+incdir+include
rtl/phy_cmd_pkg.sv
rtl/tri_sequencer.sv
rtl/cmd_field_hold.sv
rtl/cmd_slot_encoder.sv
rtl/phy_cmd_top.sv
testbench/tb_phy_cmd.sv

// ==== Bender.yml ====
package:
  name: phy_cmd

sources:
  - files:
      - rtl/phy_cmd_pkg.sv
      - rtl/tri_sequencer.sv
      - rtl/cmd_field_hold.sv
      - rtl/cmd_slot_encoder.sv
      - rtl/phy_cmd_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_phy_cmd.sv

// ==== include/phy_cmd_model.svh ====
// ############################################################
// reference model of held fields, tri history, slot and status
// ############################################################
`ifndef PHY_CMD_MODEL_SVH
`define PHY_CMD_MODEL_SVH

logic [addr_bits-1:0] model_addr;      // last non-NOP address
logic [bank_bits-1:0] model_bank;
cmd_extra_t           model_extra;     // last non-NOP controls
logic                 model_dq_prev;   // tri request seen last cycle
logic                 model_dqs_prev;

function automatic logic word_is_nop(input cmd_word_t w, input logic ap);
    return (w.rcw == 3'b000) && !ap;  // inserted pause is not a NOP
endfunction

function automatic cmd_extra_t extra_of(input cmd_word_t w);
    return {w.odt, w.cke_dis, w.sel, w.dq_en, w.dqs_en, w.dqs_toggle, w.dci_en,
            w.buf_wr, w.buf_rd, w.buf_rst};
endfunction

function automatic logic done_expect(input cmd_word_t w, input logic ap);
    return word_is_nop(w, ap) && w.addr[cmd_done_bit];
endfunction

function automatic logic [cmd_pause_bits-1:0] pause_expect(input cmd_word_t w);
    if (w.addr[cmd_done_bit]) begin
        return '0;  // done wins over pause
    end
    return w.addr[cmd_pause_bits-1:0];
endfunction

function automatic logic [slot_bits-1:0] tri_expect(input logic prev, input logic req,
                                                   input logic [half_bits-1:0] on_pat,
                                                   input logic [half_bits-1:0] off_pat);
    if (prev == req) begin
        return {slot_bits{req}};
    end
    if (prev) begin
        return {on_pat, on_pat};   // starting to drive
    end
    return {off_pat, off_pat};     // releasing the line
endfunction

function automatic phy_slot_t reset_slot();
    phy_slot_t s;
    s             = '0;
    s.ras_n       = 2'b11;
    s.cas_n       = 2'b11;
    s.we_n        = 2'b11;
    s.dq_tri      = 8'hff;
    s.dqs_tri     = 8'hff;
    s.dqs_data    = 8'hff;
    s.dci_dis_dq  = 1'b1;
    s.dci_dis_dqs = 1'b1;
    return s;
endfunction

function automatic phy_slot_t predict_slot(input cmd_word_t w, input logic ap,
                                           input logic cke, input io_pattern_t pat);
    phy_slot_t  s;
    cmd_extra_t ex;
    logic       hold;
    logic [2:0] rcw_n;
    logic [2:0] lane1;
    logic [2:0] lane0;
    hold          = word_is_nop(w, ap) || ap;
    ex            = ap ? model_extra : extra_of(w);  // pause replays old controls
    rcw_n         = ap ? 3'b111 : ~w.rcw;
    lane1         = ex.sel ? rcw_n : 3'b111;
    lane0         = ex.sel ? 3'b111 : rcw_n;
    s             = '0;
    s.addr        = hold ? {2{model_addr}} : {2{w.addr}};
    s.bank        = hold ? {2{model_bank}} : {2{w.bank}};
    s.ras_n       = {lane1[2], lane0[2]};
    s.cas_n       = {lane1[1], lane0[1]};
    s.we_n        = {lane1[0], lane0[0]};
    s.cke         = {2{~(ex.cke_dis ^ cke)}};
    s.odt         = {2{ex.odt}};
    s.dq_tri      = tri_expect(model_dq_prev, ~ex.dq_en, pat.dq_tri_on, pat.dq_tri_off);
    s.dqs_tri     = tri_expect(model_dqs_prev, ~ex.dqs_en, pat.dqs_tri_on, pat.dqs_tri_off);
    s.dqs_data    = ex.dqs_toggle ? pat.dqs_pattern : 8'hff;
    s.dci_dis_dq  = ~ex.dci_en;
    s.dci_dis_dqs = ~ex.dci_en | ex.odt;
    s.buf_wr      = ex.buf_wr;
    s.buf_rd      = ex.buf_rd;
    s.buf_rst     = ex.buf_rst;
    return s;
endfunction

task automatic update_model(input cmd_word_t w, input logic ap);
    cmd_extra_t ex;
    ex             = ap ? model_extra : extra_of(w);
    model_dq_prev  = ~ex.dq_en;
    model_dqs_prev = ~ex.dqs_en;
    if (!word_is_nop(w, ap)) begin  // pause cycles load as well
        model_addr  = w.addr;
        model_bank  = w.bank;
        model_extra = extra_of(w);
    end
endtask

task automatic reset_model();
    model_addr     = '0;
    model_bank     = '0;
    model_extra    = '0;
    model_dq_prev  = 1'b1;
    model_dqs_prev = 1'b1;
endtask

`endif

// ==== testbench/tb_phy_cmd.sv ====
// ############################################################
// testbench for the DDR3 command path with random words and a model
// ############################################################
`timescale 1ns/1ns

module tb_phy_cmd import phy_cmd_pkg::*; ();

    localparam int reset_cycles = 3;
    localparam int test_cycles  = 400;  // per random test
    localparam int num_tests    = 5;
    localparam int total_cycles = reset_cycles + 2 + num_tests * test_cycles;

    logic                      mclk;
    logic                      rst_in;
    cmd_word_t                 cmd_word;
    logic                      add_pause;
    logic                      ddr_cke;
    io_pattern_t               patterns;
    phy_slot_t                 slot;
    logic                      phy_cmd_nop;
    logic                      phy_cmd_add_pause;
    logic                      sequence_done;
    logic [cmd_pause_bits-1:0] pause_len;

    integer    seed;
    int        errors;
    int        checks;
    int        tests;
    phy_slot_t exp_slot;  // due after the coming rising edge
    logic      dq_run;    // slow moving enables for tri test
    logic      dqs_run;

    `include "phy_cmd_model.svh"

    phy_cmd_top dut0 (
        .mclk              (mclk),
        .rst_in            (rst_in),
        .cmd_word          (cmd_word),
        .add_pause         (add_pause),
        .ddr_cke           (ddr_cke),
        .patterns          (patterns),
        .slot              (slot),
        .phy_cmd_nop       (phy_cmd_nop),
        .phy_cmd_add_pause (phy_cmd_add_pause),
        .sequence_done     (sequence_done),
        .pause_len         (pause_len)
    );

    initial begin
        mclk = 1'b0;
        forever #4 mclk = ~mclk;  // 8 ns period
    end

    initial begin
        #(total_cycles * 8 * 2);
        $display("timeout: run did not finish within %0d ns", total_cycles * 16);
        $display("ERRORS FOUND");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: expected %0h, got %0h at %0t", name, exp, got, $time);
        end
    endtask

    task automatic check_slot(input phy_slot_t got, input phy_slot_t exp);
        check_value("slot.addr", got.addr, exp.addr);
        check_value("slot.bank", got.bank, exp.bank);
        check_value("slot.ras_n", got.ras_n, exp.ras_n);
        check_value("slot.cas_n", got.cas_n, exp.cas_n);
        check_value("slot.we_n", got.we_n, exp.we_n);
        check_value("slot.cke", got.cke, exp.cke);
        check_value("slot.odt", got.odt, exp.odt);
        check_value("slot.dq_tri", got.dq_tri, exp.dq_tri);
        check_value("slot.dqs_tri", got.dqs_tri, exp.dqs_tri);
        check_value("slot.dqs_data", got.dqs_data, exp.dqs_data);
        check_value("slot.dci_dis_dq", got.dci_dis_dq, exp.dci_dis_dq);
        check_value("slot.dci_dis_dqs", got.dci_dis_dqs, exp.dci_dis_dqs);
        check_value("slot.buf_wr", got.buf_wr, exp.buf_wr);
        check_value("slot.buf_rd", got.buf_rd, exp.buf_rd);
        check_value("slot.buf_rst", got.buf_rst, exp.buf_rst);
    endtask

    // drive one word, predict its slot and check the status in the same cycle
    task automatic apply_inputs(input cmd_word_t w, input logic ap, input logic cke,
                                input io_pattern_t pat);
        cmd_word  = w;
        add_pause = ap;
        ddr_cke   = cke;
        patterns  = pat;
        exp_slot  = predict_slot(w, ap, cke, pat);
        update_model(w, ap);
        #1;
        check_value("phy_cmd_nop", phy_cmd_nop, word_is_nop(w, ap));
        check_value("phy_cmd_add_pause", phy_cmd_add_pause, w.add_pause);
        check_value("sequence_done", sequence_done, done_expect(w, ap));
        check_value("pause_len", pause_len, pause_expect(w));
    endtask

    task automatic run_cycle(input cmd_word_t w, input logic ap, input logic cke,
                             input io_pattern_t pat);
        @(negedge mclk);
        check_slot(slot, exp_slot);  // result of the previous word
        apply_inputs(w, ap, cke, pat);
    endtask

    task automatic gen_word(input int mode, output cmd_word_t w, output logic ap);
        w  = $random(seed);
        ap = 1'b0;
        case (mode)
            0: if (w.rcw == 3'b000) w.rcw = 3'b101;            // real command only
            1: if (($random(seed) & 3) != 0) w.rcw = 3'b000;   // mostly NOPs
            2: ap = $random(seed) & 1;
            3: begin
                if (($random(seed) & 3) == 0) dq_run = ~dq_run;
                if (($random(seed) & 3) == 0) dqs_run = ~dqs_run;
                w.dq_en  = dq_run;
                w.dqs_en = dqs_run;
            end
            default: ap = (($random(seed) & 7) == 0);  // rare pause
        endcase
    endtask

    task automatic report_test(input string name, input int start);
        tests++;
        if (errors == start) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: failed with %0d mismatches", name, errors - start);
        end
    endtask

    task automatic run_test(input string name, input int mode);
        int          start;
        cmd_word_t   w;
        logic        ap;
        logic [31:0] rnd;
        io_pattern_t pat;
        start = errors;
        rnd   = $random(seed);
        pat   = rnd[23:0];  // fresh static patterns per test
        repeat (test_cycles) begin
            gen_word(mode, w, ap);
            rnd = $random(seed);
            run_cycle(w, ap, rnd[0], pat);
        end
        report_test(name, start);
    endtask

    initial begin
        seed      = 32'he6cda422;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        rst_in    = 1'b1;
        cmd_word  = '0;
        add_pause = 1'b0;
        ddr_cke   = 1'b0;
        patterns  = '0;
        dq_run    = 1'b0;
        dqs_run   = 1'b0;
        reset_model();
        exp_slot = reset_slot();
        #1;  // skip the time zero clock edge
        repeat (reset_cycles) begin
            @(negedge mclk);
            check_slot(slot, exp_slot);  // held in reset
        end
        rst_in = 1'b0;
        apply_inputs('0, 1'b0, 1'b0, '0);
        check_slot(slot, reset_slot());  // no edge since release yet
        report_test("reset", 0);
        run_test("decode", 0);
        run_test("nop_done_pause", 1);
        run_test("add_pause", 2);
        run_test("tristate", 3);
        run_test("dci_dqs", 4);
        @(negedge mclk);
        check_slot(slot, exp_slot);  // last word of the run
        $display("%0d tests, %0d checks, %0d mismatches", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== rtl/phy_cmd_top.sv ====
// ##########################################################
// DDR3 PHY command path top with field hold and slot encoder
// ##########################################################
`timescale 1ns/1ns

module phy_cmd_top import phy_cmd_pkg::*; (
    input  logic                      mclk,
    input  logic                      rst_in,
    input  cmd_word_t                 cmd_word,           // one word every mclk
    input  logic                      add_pause,          // sequencer inserted pause
    input  logic                      ddr_cke,            // cke polarity, xor-ed with cke_dis
    input  io_pattern_t               patterns,           // static
    output phy_slot_t                 slot,               // to serializer, 1 cycle later
    output logic                      phy_cmd_nop,
    output logic                      phy_cmd_add_pause,
    output logic                      sequence_done,
    output logic [cmd_pause_bits-1:0] pause_len
);

    logic [addr_bits-1:0] cur_addr;   // quiet address, held over NOPs
    logic [bank_bits-1:0] cur_bank;
    logic [rcw_bits-1:0]  cur_rcw;    // zeroed under add_pause
    cmd_extra_t           cur_extra;

    cmd_field_hold hold0 (
        .mclk              (mclk),
        .rst_in            (rst_in),
        .cmd_word          (cmd_word),
        .add_pause         (add_pause),
        .cur_addr          (cur_addr),
        .cur_bank          (cur_bank),
        .cur_rcw           (cur_rcw),
        .cur_extra         (cur_extra),
        .phy_cmd_nop       (phy_cmd_nop),
        .phy_cmd_add_pause (phy_cmd_add_pause),
        .sequence_done     (sequence_done),
        .pause_len         (pause_len)
    );

    cmd_slot_encoder enc0 (
        .mclk      (mclk),
        .rst_in    (rst_in),
        .cur_addr  (cur_addr),
        .cur_bank  (cur_bank),
        .cur_rcw   (cur_rcw),
        .cur_extra (cur_extra),
        .ddr_cke   (ddr_cke),
        .patterns  (patterns),
        .slot      (slot)
    );

endmodule

// ==== rtl/cmd_slot_encoder.sv ====
// ##########################################################
// two-lane half-cycle slot expansion and output register
// ##########################################################
`timescale 1ns/1ns

module cmd_slot_encoder import phy_cmd_pkg::*; (
    input  logic                 mclk,
    input  logic                 rst_in,
    input  logic [addr_bits-1:0] cur_addr,
    input  logic [bank_bits-1:0] cur_bank,
    input  logic [rcw_bits-1:0]  cur_rcw,    // active high, 0 = NOP
    input  cmd_extra_t           cur_extra,
    input  logic                 ddr_cke,    // global cke polarity
    input  io_pattern_t          patterns,
    output phy_slot_t            slot
);

    logic [rcw_bits-1:0]    rcw_n;       // active low command
    logic [rcw_bits-1:0]    lane1_rcw;
    logic [rcw_bits-1:0]    lane0_rcw;
    logic                   cke_bit;
    logic [2*addr_bits-1:0] addr_q;
    logic [2*bank_bits-1:0] bank_q;
    logic [1:0]             ras_n_q;
    logic [1:0]             cas_n_q;
    logic [1:0]             we_n_q;
    logic [1:0]             cke_q;
    logic [1:0]             odt_q;
    logic [slot_bits-1:0]   dqs_data_q;
    logic                   dci_dq_q;
    logic                   dci_dqs_q;
    logic                   buf_wr_q;
    logic                   buf_rd_q;
    logic                   buf_rst_q;
    logic [slot_bits-1:0]   dq_tri_w;    // from sequencers, already registered
    logic [slot_bits-1:0]   dqs_tri_w;

    assign rcw_n     = ~cur_rcw;
    assign lane1_rcw = cur_extra.sel ? rcw_n : '1;  // other lane idles as NOP
    assign lane0_rcw = cur_extra.sel ? '1 : rcw_n;
    assign cke_bit   = ~(cur_extra.cke_dis ^ ddr_cke);

    always_ff @(posedge mclk or posedge rst_in) begin
        if (rst_in) begin
            addr_q     <= slot_reset.addr;
            bank_q     <= slot_reset.bank;
            ras_n_q    <= slot_reset.ras_n;
            cas_n_q    <= slot_reset.cas_n;
            we_n_q     <= slot_reset.we_n;
            cke_q      <= slot_reset.cke;
            odt_q      <= slot_reset.odt;
            dqs_data_q <= slot_reset.dqs_data;
            dci_dq_q   <= slot_reset.dci_dis_dq;
            dci_dqs_q  <= slot_reset.dci_dis_dqs;
            buf_wr_q   <= slot_reset.buf_wr;
            buf_rd_q   <= slot_reset.buf_rd;
            buf_rst_q  <= slot_reset.buf_rst;
        end else begin
            addr_q     <= {cur_addr, cur_addr};        // same address both lanes
            bank_q     <= {cur_bank, cur_bank};
            ras_n_q    <= {lane1_rcw[2], lane0_rcw[2]};
            cas_n_q    <= {lane1_rcw[1], lane0_rcw[1]};
            we_n_q     <= {lane1_rcw[0], lane0_rcw[0]};
            cke_q      <= {2{cke_bit}};
            odt_q      <= {2{cur_extra.odt}};
            dqs_data_q <= cur_extra.dqs_toggle ? patterns.dqs_pattern : '1;
            dci_dq_q   <= ~cur_extra.dci_en;
            dci_dqs_q  <= ~cur_extra.dci_en | cur_extra.odt;  // write leveling keeps dqs dci off
            buf_wr_q   <= cur_extra.buf_wr;
            buf_rd_q   <= cur_extra.buf_rd;
            buf_rst_q  <= cur_extra.buf_rst;
        end
    end

    tri_sequencer dq_seq0 (
        .mclk        (mclk),
        .rst_in      (rst_in),
        .tri_in      (~cur_extra.dq_en),
        .on_pattern  (patterns.dq_tri_on),
        .off_pattern (patterns.dq_tri_off),
        .tri_word    (dq_tri_w)
    );

    tri_sequencer dqs_seq0 (
        .mclk        (mclk),
        .rst_in      (rst_in),
        .tri_in      (~cur_extra.dqs_en),
        .on_pattern  (patterns.dqs_tri_on),
        .off_pattern (patterns.dqs_tri_off),
        .tri_word    (dqs_tri_w)
    );

    assign slot = '{
        addr:        addr_q,
        bank:        bank_q,
        ras_n:       ras_n_q,
        cas_n:       cas_n_q,
        we_n:        we_n_q,
        cke:         cke_q,
        odt:         odt_q,
        dq_tri:      dq_tri_w,
        dqs_tri:     dqs_tri_w,
        dqs_data:    dqs_data_q,
        dci_dis_dq:  dci_dq_q,
        dci_dis_dqs: dci_dqs_q,
        buf_wr:      buf_wr_q,
        buf_rd:      buf_rd_q,
        buf_rst:     buf_rst_q
    };

    // never two real commands in one mclk
    a_one_lane_cmd: assert property (@(posedge mclk) disable iff (rst_in)
        !(({slot.ras_n[1], slot.cas_n[1], slot.we_n[1]} != 3'b111) &&
          ({slot.ras_n[0], slot.cas_n[0], slot.we_n[0]} != 3'b111)));

endmodule

// ==== rtl/cmd_field_hold.sv ====
// ##########################################################
// NOP/pause field selection, held fields, sequencer status
// ##########################################################
`timescale 1ns/1ns

module cmd_field_hold import phy_cmd_pkg::*; (
    input  logic                      mclk,
    input  logic                      rst_in,
    input  cmd_word_t                 cmd_word,
    input  logic                      add_pause,          // repeat last controls with NOP
    output logic [addr_bits-1:0]      cur_addr,
    output logic [bank_bits-1:0]      cur_bank,
    output logic [rcw_bits-1:0]       cur_rcw,
    output cmd_extra_t                cur_extra,
    output logic                      phy_cmd_nop,
    output logic                      phy_cmd_add_pause,
    output logic                      sequence_done,
    output logic [cmd_pause_bits-1:0] pause_len
);

    logic [addr_bits-1:0] addr_hold;   // last non-NOP address
    logic [bank_bits-1:0] bank_hold;
    cmd_extra_t           extra_hold;  // last non-NOP controls
    cmd_extra_t           word_extra;
    logic                 use_hold;    // keep addr/bank quiet
    logic                 done_flag;

    assign word_extra = '{
        odt:        cmd_word.odt,
        cke_dis:    cmd_word.cke_dis,
        sel:        cmd_word.sel,
        dq_en:      cmd_word.dq_en,
        dqs_en:     cmd_word.dqs_en,
        dqs_toggle: cmd_word.dqs_toggle,
        dci_en:     cmd_word.dci_en,
        buf_wr:     cmd_word.buf_wr,
        buf_rd:     cmd_word.buf_rd,
        buf_rst:    cmd_word.buf_rst
    };

    assign phy_cmd_nop       = (cmd_word.rcw == '0) && !add_pause;  // inserted NOP not counted
    assign phy_cmd_add_pause = cmd_word.add_pause;                  // word asks for one pause
    assign use_hold          = phy_cmd_nop || add_pause;

    assign cur_addr  = use_hold ? addr_hold : cmd_word.addr;
    assign cur_bank  = use_hold ? bank_hold : cmd_word.bank;
    assign cur_rcw   = add_pause ? '0 : cmd_word.rcw;              // replay as NOP
    assign cur_extra = add_pause ? extra_hold : word_extra;

    assign done_flag     = cmd_word.addr[cmd_done_bit];
    assign sequence_done = phy_cmd_nop && done_flag;
    assign pause_len     = done_flag ? '0 : cmd_word.addr[cmd_pause_bits-1:0];  // no pause with done

    always_ff @(posedge mclk or posedge rst_in) begin
        if (rst_in) begin
            addr_hold  <= '0;
            bank_hold  <= '0;
            extra_hold <= '0;
        end else if (!phy_cmd_nop) begin  // pause cycles load too
            addr_hold  <= cmd_word.addr;
            bank_hold  <= cmd_word.bank;
            extra_hold <= word_extra;
        end
    end

    // done must never come with a pending pause
    a_done_no_pause: assert property (@(posedge mclk) disable iff (rst_in)
        sequence_done |-> pause_len == '0);

endmodule

// ==== rtl/tri_sequencer.sv ====
// ##########################################################
// tristate edge sequencer for one DQ or DQS group
// ##########################################################
`timescale 1ns/1ns

module tri_sequencer import phy_cmd_pkg::*; (
    input  logic                 mclk,
    input  logic                 rst_in,
    input  logic                 tri_in,       // 1 = tristate requested
    input  logic [half_bits-1:0] on_pattern,   // tri bits on enable edge
    input  logic [half_bits-1:0] off_pattern,  // tri bits on disable edge
    output logic [slot_bits-1:0] tri_word      // per-slot tri word
);

    logic                 tri_prev;   // request from last cycle
    logic [slot_bits-1:0] tri_next;

    // steady state replicates and an edge plays its pattern in both lanes
    always_comb begin
        if (tri_prev == tri_in) begin
            tri_next = {slot_bits{tri_in}};
        end else if (tri_prev) begin
            tri_next = {on_pattern, on_pattern};    // tristate -> driving
        end else begin
            tri_next = {off_pattern, off_pattern};  // driving -> tristate
        end
    end

    always_ff @(posedge mclk or posedge rst_in) begin
        if (rst_in) begin
            tri_prev <= 1'b1;               // lines start released
            tri_word <= {slot_bits{1'b1}};
        end else begin
            tri_prev <= tri_in;
            tri_word <= tri_next;
        end
    end

endmodule

// ==== rtl/phy_cmd_pkg.sv ====
// ##########################################################
// DDR3 PHY command path types, widths and reset slot value
// ##########################################################
package phy_cmd_pkg;

    localparam int addr_bits      = 15;  // row/column address
    localparam int bank_bits      = 3;   // bank address
    localparam int rcw_bits       = 3;   // ras, cas, we
    localparam int cmd_pause_bits = 10;  // pause length lives in low addr bits on NOP
    localparam int cmd_done_bit   = 10;  // addr bit flagging end of sequence on NOP
    localparam int slot_bits      = 8;   // tri/dqs bits per mclk, two lanes of four
    localparam int half_bits      = 4;   // one tri pattern half

    // sequencer command word listed from the msb
    typedef struct packed {
        logic [addr_bits-1:0] addr;        // also pause length / done flag on NOP
        logic [bank_bits-1:0] bank;
        logic [rcw_bits-1:0]  rcw;         // active high ras/cas/we, 0 = NOP
        logic                 odt;
        logic                 cke_dis;     // xor-ed with ddr_cke
        logic                 sel;         // lane 1 when set
        logic                 dq_en;
        logic                 dqs_en;
        logic                 dqs_toggle;  // drive dqs pattern
        logic                 dci_en;
        logic                 buf_wr;      // external buffer strobes
        logic                 buf_rd;
        logic                 add_pause;   // reported back to sequencer
        logic                 buf_rst;
    } cmd_word_t;

    // control bits replayed under add_pause
    typedef struct packed {
        logic odt;
        logic cke_dis;
        logic sel;
        logic dq_en;
        logic dqs_en;
        logic dqs_toggle;
        logic dci_en;
        logic buf_wr;
        logic buf_rd;
        logic buf_rst;
    } cmd_extra_t;

    // static i/o timing patterns
    typedef struct packed {
        logic [slot_bits-1:0] dqs_pattern;  // usually 8'h55
        logic [half_bits-1:0] dq_tri_on;    // first word when enabling dq
        logic [half_bits-1:0] dq_tri_off;   // first word after disabling dq
        logic [half_bits-1:0] dqs_tri_on;
        logic [half_bits-1:0] dqs_tri_off;
    } io_pattern_t;

    // registered slot for the serializer with lane 1 in the upper half
    typedef struct packed {
        logic [2*addr_bits-1:0] addr;
        logic [2*bank_bits-1:0] bank;
        logic [1:0]             ras_n;        // indexed by lane
        logic [1:0]             cas_n;
        logic [1:0]             we_n;
        logic [1:0]             cke;
        logic [1:0]             odt;
        logic [slot_bits-1:0]   dq_tri;       // 1 = tristate
        logic [slot_bits-1:0]   dqs_tri;
        logic [slot_bits-1:0]   dqs_data;
        logic                   dci_dis_dq;
        logic                   dci_dis_dqs;
        logic                   buf_wr;
        logic                   buf_rd;
        logic                   buf_rst;
    } phy_slot_t;

    // NOP on both lanes and outputs off while in reset
    localparam phy_slot_t slot_reset = '{
        addr:        '0,
        bank:        '0,
        ras_n:       2'b11,
        cas_n:       2'b11,
        we_n:        2'b11,
        cke:         2'b00,
        odt:         2'b00,
        dq_tri:      '1,
        dqs_tri:     '1,
        dqs_data:    '1,
        dci_dis_dq:  1'b1,
        dci_dis_dqs: 1'b1,
        buf_wr:      1'b0,
        buf_rd:      1'b0,
        buf_rst:     1'b0
    };

endpackage
